// ==== Makefile ====
VERILATOR  := verilator
TOP        := xc_tb
FILELIST   := files.f
OBJ_DIR    := obj_dir
BUILD_FLAGS := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG   := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass message in the output
run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/xc_chk.sv ====
// ========================================
// Correlator protocol checker
// Sequencer state, clear pulse and
// readout stream properties
// ========================================

`timescale 1ns/1ps

module xc_chk
	import xc_pkg::*;
(
	input logic       intclk,
	input logic       rst,
	input seq_state_e state,
	input logic       clear,
	input logic       busy,
	input logic       out_valid,
	input logic       frame_done
);

	out_in_readout: assert property (@(posedge intclk) disable iff (rst)
		out_valid |-> state == READOUT)
		else $error("out_valid high outside READOUT");

	done_with_word: assert property (@(posedge intclk) disable iff (rst)
		frame_done |-> out_valid)
		else $error("frame_done high without out_valid");

	// Clear is a single cycle pulse
	clear_single: assert property (@(posedge intclk) disable iff (rst)
		clear |=> !clear)
		else $error("clear high for two consecutive cycles");

	idle_after_reset: assert property (@(posedge intclk)
		rst |=> !busy)
		else $error("busy high one cycle after reset");

endmodule

bind xc_top xc_chk u_chk (
	.intclk     (intclk),
	.rst        (rst),
	.state      (u_seq.state),
	.clear      (corr_ctl.clear),
	.busy       (busy),
	.out_valid  (out_valid),
	.frame_done (frame_done)
);

// ==== dv/xc_tb.sv ====
// ========================================
// Correlator testbench
// Directed tests checked against a
// reference model of the counting rule
// ========================================

`timescale 1ns/1ps

`include "xc_macros.svh"

module xc_tb
	import xc_pkg::*;
();

	localparam int NL              = `XC_NUM_LINES;
	localparam int LAGS            = `XC_LAGS;
	localparam int RES             = `XC_RESOLUTION;
	localparam int NWORDS          = `XC_NUM_WORDS;
	localparam int READOUT_TIMEOUT = 200;

	logic          intclk = 1'b0;
	logic          rst;
	logic [NL-1:0] line_in;
	logic          sample_valid;
	cmd_u          cmd;
	logic          cmd_valid;
	logic          busy;
	out_word_t     out;
	logic          out_valid;
	logic          frame_done;

	int   seed = 70504;
	int   errors = 0;
	int   tests_run = 0;
	int   tests_bad = 0;
	logic hist [NL][LAGS];
	int   exp_cnt [NWORDS];

	xc_top u_dut (
		.intclk       (intclk),
		.rst          (rst),
		.line_in      (line_in),
		.sample_valid (sample_valid),
		.cmd          (cmd),
		.cmd_valid    (cmd_valid),
		.busy         (busy),
		.out          (out),
		.out_valid    (out_valid),
		.frame_done   (frame_done)
	);

	always #10 intclk = ~intclk;

	// ========================================
	// Reference model
	// ========================================
	function automatic void clear_model();
		for (int a = 0; a < NL; a++)
			for (int k = 0; k < LAGS; k++)
				hist[a][k] = 1'b0;
		for (int w = 0; w < NWORDS; w++)
			exp_cnt[w] = 0;
	endfunction

	function automatic void bump_count(input int w);
		if (exp_cnt[w] < (1 << RES) - 1)
			exp_cnt[w]++;
	endfunction

	// Slot k of a line holds its sample k accepts ago and slot 0 the new one
	function automatic void model_accept(input logic [NL-1:0] l);
		int p;
		p = 0;
		for (int a = 0; a < NL; a++) begin
			for (int k = LAGS - 1; k > 0; k--)
				hist[a][k] = hist[a][k-1];
			hist[a][0] = l[a];
		end
		for (int a = 0; a < NL; a++)
			for (int k = 0; k < LAGS; k++)
				if (hist[a][0] && hist[a][k])
					bump_count(a * LAGS + k);
		for (int a = 0; a < NL; a++) begin
			for (int b = a + 1; b < NL; b++) begin
				for (int k = 0; k < LAGS; k++)
					if (hist[a][0] && hist[b][k])
						bump_count(NL * LAGS + p * LAGS + k);
				p++;
			end
		end
	endfunction

	// ========================================
	// Drivers and monitors
	// ========================================
	task automatic flag_error(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic apply_reset();
		@(posedge intclk);
		rst          <= 1'b1;
		cmd_valid    <= 1'b0;
		sample_valid <= 1'b0;
		repeat (2) @(posedge intclk);
		rst <= 1'b0;
	endtask

	// Command is taken on the second edge and the task returns there
	task automatic send_cmd(input cmd_op_e op, input logic [5:0] arg);
		@(posedge intclk);
		cmd       <= {op, arg};
		cmd_valid <= 1'b1;
		@(posedge intclk);
		cmd_valid <= 1'b0;
		cmd       <= '0;
	endtask

	// Feeds n accepted samples when called just after the CLEAR cycle began
	task automatic run_frame(input int n, input bit ones);
		int            acc;
		logic [NL-1:0] l;
		logic          v;
		acc = 0;
		clear_model();
		@(posedge intclk);
		while (acc < n) begin
			if (ones) begin
				l = '1;
				v = 1'b1;
			end else begin
				l = NL'($random(seed));
				v = 1'($random(seed));
			end
			line_in      <= l;
			sample_valid <= v;
			if (v) begin
				model_accept(l);
				acc++;
			end
			@(posedge intclk);
		end
		sample_valid <= 1'b0;
	endtask

	task automatic collect_frame();
		int waited;
		bit seen;
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < READOUT_TIMEOUT) begin
			@(negedge intclk);
			if (out_valid)
				seen = 1'b1;
			else
				waited++;
		end
		if (!seen) begin
			$display("Timeout: no readout word arrived within %0d cycles", READOUT_TIMEOUT);
			errors++;
		end else begin
			for (int n = 0; n < NWORDS; n++) begin
				if (n > 0)
					@(negedge intclk);
				assert (out_valid && out.index == 8'(n))
				else flag_error($sformatf("word %0d missing, index %0d", n, out.index));
				assert (int'(out.count) == exp_cnt[n])
				else flag_error($sformatf("word %0d count %0d, expected %0d",
					n, out.count, exp_cnt[n]));
				assert (frame_done == (n == NWORDS - 1))
				else flag_error($sformatf("frame_done wrong at word %0d", n));
			end
		end
	endtask

	task automatic hold_quiet(input int cycles, input bit drive_ones);
		for (int c = 0; c < cycles; c++) begin
			@(posedge intclk);
			if (drive_ones) begin
				line_in      <= '1;
				sample_valid <= 1'b1;
			end
			@(negedge intclk);
			assert (!out_valid && !frame_done)
			else flag_error("readout word while none expected");
		end
		@(posedge intclk);
		sample_valid <= 1'b0;
	endtask

	task automatic report_test(input string name, input int errs_at_start);
		tests_run++;
		if (errors == errs_at_start) begin
			$display("[ ok ] %s", name);
		end else begin
			tests_bad++;
			$display("[bad ] %s: %0d errors", name, errors - errs_at_start);
		end
	endtask

	// ========================================
	// Tests
	// ========================================
	task automatic check_reset_state();
		int e0;
		e0 = errors;
		apply_reset();
		@(negedge intclk);
		assert (!busy && !out_valid && !frame_done)
		else flag_error("outputs not idle after reset");
		// Commands other than START and offered samples start nothing
		send_cmd(OP_NOP, 6'b100000);
		send_cmd(OP_SET_LEN, 6'd4);
		hold_quiet(40, 1'b1);
		report_test("reset state", e0);
	endtask

	task automatic all_ones_frame();
		int e0;
		e0 = errors;
		apply_reset();
		send_cmd(OP_SET_LEN, 6'd3);
		send_cmd(OP_START, 6'd0);
		run_frame(8, 1'b1);
		// Every product is one and lag k misses the first k samples
		for (int w = 0; w < NWORDS; w++)
			exp_cnt[w] = 8 - (w % LAGS);
		collect_frame();
		report_test("all ones, length 8", e0);
	endtask

	task automatic random_frame();
		int e0;
		e0 = errors;
		apply_reset();
		send_cmd(OP_START, 6'd0);
		run_frame(1 << `XC_LEN_DEFAULT, 1'b0);
		collect_frame();
		report_test("random lines, default length", e0);
	endtask

	task automatic continuous_frames();
		int e0;
		e0 = errors;
		apply_reset();
		send_cmd(OP_START, 6'b100000);
		run_frame(16, 1'b0);
		collect_frame();
		// Next edge enters CLEAR and the one after that INTEGRATE
		@(posedge intclk);
		@(negedge intclk);
		assert (busy)
		else flag_error("busy dropped between continuous frames");
		run_frame(16, 1'b0);
		collect_frame();
		send_cmd(OP_ABORT, 6'd0);
		report_test("continuous mode", e0);
	endtask

	task automatic abort_integration();
		int e0;
		e0 = errors;
		apply_reset();
		send_cmd(OP_START, 6'd0);
		// Part of a period is accepted before the ABORT
		hold_quiet(5, 1'b1);
		send_cmd(OP_ABORT, 6'd0);
		@(negedge intclk);
		assert (!busy)
		else flag_error("busy still high after ABORT");
		hold_quiet(60, 1'b1);
		send_cmd(OP_START, 6'd0);
		run_frame(16, 1'b0);
		collect_frame();
		report_test("abort during integration", e0);
	endtask

	task automatic length_handling();
		int e0;
		e0 = errors;
		apply_reset();
		send_cmd(OP_SET_LEN, 6'd63);
		@(negedge intclk);
		assert (u_dut.len_log2 == 6'(`XC_LEN_MAX))
		else flag_error($sformatf("length %0d not clamped", u_dut.len_log2));
		send_cmd(OP_START, 6'd0);
		hold_quiet(300, 1'b1);
		send_cmd(OP_ABORT, 6'd0);
		// A SET_LEN during integration must not change the running length
		send_cmd(OP_SET_LEN, 6'd2);
		send_cmd(OP_START, 6'd0);
		send_cmd(OP_SET_LEN, 6'd5);
		run_frame(4, 1'b1);
		collect_frame();
		report_test("length clamp and busy SET_LEN", e0);
	endtask

	initial begin
		rst          <= 1'b1;
		line_in      <= '0;
		sample_valid <= 1'b0;
		cmd          <= '0;
		cmd_valid    <= 1'b0;
		check_reset_state();
		all_ones_frame();
		random_frame();
		continuous_frames();
		abort_integration();
		length_handling();
		$display("Summary: %0d tests, %0d with errors, %0d errors", tests_run, tests_bad, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// Hang guard for the whole run
	initial begin
		#2ms;
		$display("Watchdog expired before all tests finished");
		$display("Test failed");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+source
source/xc_pkg.sv
source/xc_sequencer.sv
source/xc_integ_timer.sv
source/xc_delay_line.sv
source/xc_corr_bank.sv
source/xc_readout.sv
source/xc_top.sv
dv/xc_chk.sv
dv/xc_tb.sv

// ==== source/xc_corr_bank.sv ====
// ========================================
// Correlation counter bank
// Saturating auto and cross counters in
// readout word order
// ========================================

`timescale 1ns/1ps

`include "xc_macros.svh"

module xc_corr_bank
	import xc_pkg::*;
(
	input  logic                                        intclk,
	input  logic                                        rst,
	input  corr_ctl_t                                   corr_ctl,
	input  logic [`XC_NUM_LINES-1:0]                    line_in,
	input  logic [`XC_NUM_LINES*(`XC_LAGS-1)-1:0]       history,
	output logic [`XC_NUM_WORDS*`XC_RESOLUTION-1:0]     counts
);

	localparam int NL    = `XC_NUM_LINES;
	localparam int LAGS  = `XC_LAGS;
	localparam int RES   = `XC_RESOLUTION;
	localparam int WORDS = `XC_NUM_WORDS;

	// Tap k of a line is its sample k accepts earlier, tap 0 is live
	logic [LAGS-1:0]  taps [NL];
	logic [WORDS-1:0] hit;

	// ========================================
	// Products
	// ========================================
	for (genvar a = 0; a < NL; a++) begin : g_line
		assign taps[a][0] = line_in[a];
		for (genvar k = 1; k < LAGS; k++) begin : g_tap
			assign taps[a][k] = history[a*(LAGS-1)+k-1];
		end

		for (genvar k = 0; k < LAGS; k++) begin : g_auto
			assign hit[a*LAGS+k] = taps[a][0] & taps[a][k];
		end

		// Pair number follows (0,1),(0,2),...,(NL-2,NL-1)
		for (genvar b = a + 1; b < NL; b++) begin : g_pair
			localparam int P = a * (2 * NL - a - 1) / 2 + (b - a - 1);
			for (genvar k = 0; k < LAGS; k++) begin : g_cross
				assign hit[NL*LAGS+P*LAGS+k] = taps[a][0] & taps[b][k];
			end
		end
	end

	// ========================================
	// Saturating counters
	// ========================================
	for (genvar w = 0; w < WORDS; w++) begin : g_cnt
		always_ff @(posedge intclk) begin
			if (rst || corr_ctl.clear) begin
				counts[w*RES+:RES] <= '0;
			end else if (corr_ctl.accept && hit[w] && counts[w*RES+:RES] != '1) begin
				counts[w*RES+:RES] <= counts[w*RES+:RES] + 1'b1;
			end
		end
	end

endmodule

// ==== source/xc_delay_line.sv ====
// ========================================
// Sample history
// One shift register per line holding the
// last LAGS-1 accepted samples
// ========================================

`timescale 1ns/1ps

`include "xc_macros.svh"

module xc_delay_line
	import xc_pkg::*;
(
	input  logic                                       intclk,
	input  logic                                       rst,
	input  corr_ctl_t                                  corr_ctl,
	input  logic [`XC_NUM_LINES-1:0]                   line_in,
	output logic [`XC_NUM_LINES*(`XC_LAGS-1)-1:0]      history
);

	localparam int DEPTH = `XC_LAGS - 1;

	// Bit l*DEPTH + k-1 holds line l from k accepts ago
	always_ff @(posedge intclk) begin
		if (rst || corr_ctl.clear) begin
			history <= '0;
		end else if (corr_ctl.accept) begin
			for (int l = 0; l < `XC_NUM_LINES; l++) begin
				for (int k = DEPTH - 1; k > 0; k--)
					history[l*DEPTH+k] <= history[l*DEPTH+k-1];
				history[l*DEPTH] <= line_in[l];
			end
		end
	end

endmodule

// ==== source/xc_integ_timer.sv ====
// ========================================
// Integration timer
// Counts accepted samples and flags the
// end of a 2^len_log2 period
// ========================================

`timescale 1ns/1ps

`include "xc_macros.svh"

module xc_integ_timer
	import xc_pkg::*;
(
	input  logic       intclk,
	input  logic       rst,
	input  corr_ctl_t  corr_ctl,
	input  logic [5:0] len_log2,
	output logic       period_done
);

	localparam int CNT_W = `XC_LEN_MAX + 1;

	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] final_count;

	// Count value held just before the closing accept
	assign final_count = ({{(CNT_W-1){1'b0}}, 1'b1} << len_log2) - 1'b1;

	assign period_done = corr_ctl.accept && (count == final_count);

	always_ff @(posedge intclk) begin
		if (rst || corr_ctl.clear) begin
			count <= '0;
		end else if (corr_ctl.accept) begin
			count <= period_done ? '0 : count + 1'b1;
		end
	end

endmodule

// ==== source/xc_macros.svh ====
// ========================================
// Correlator sizing macros
// Line count, lag count, counter width
// and integration length limits
// ========================================

`ifndef XC_MACROS_SVH
`define XC_MACROS_SVH

`define XC_NUM_LINES    4
`define XC_LAGS         4
`define XC_RESOLUTION   16

// Integration length exponent after reset and its upper clamp
`define XC_LEN_DEFAULT  4
`define XC_LEN_MAX      20

// Derived counts
`define XC_NUM_PAIRS    (`XC_NUM_LINES * (`XC_NUM_LINES - 1) / 2)
`define XC_NUM_WORDS    ((`XC_NUM_LINES + `XC_NUM_PAIRS) * `XC_LAGS)

`endif

// ==== source/xc_pkg.sv ====
// ========================================
// Correlator types
// Command word, control and output
// structs, sequencer states
// ========================================

`include "xc_macros.svh"

package xc_pkg;

	typedef enum logic [1:0] {
		OP_NOP     = 2'd0,
		OP_SET_LEN = 2'd1,
		OP_START   = 2'd2,
		OP_ABORT   = 2'd3
	} cmd_op_e;

	// SET_LEN view of the command word
	typedef struct packed {
		cmd_op_e    op;
		logic [5:0] len_log2;
	} cmd_len_t;

	// START view of the command word
	typedef struct packed {
		cmd_op_e    op;
		logic       continuous;
		logic [4:0] rsvd;
	} cmd_run_t;

	typedef union packed {
		cmd_len_t len;
		cmd_run_t run;
	} cmd_u;

	typedef struct packed {
		logic clear;
		logic accept;
	} corr_ctl_t;

	typedef struct packed {
		logic [7:0]                index;
		logic [`XC_RESOLUTION-1:0] count;
	} out_word_t;

	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		CLEAR     = 2'd1,
		INTEGRATE = 2'd2,
		READOUT   = 2'd3
	} seq_state_e;

endpackage

// ==== source/xc_readout.sv ====
// ========================================
// Readout streamer
// Sends every counter as one indexed
// word per cycle after a start pulse
// ========================================

`timescale 1ns/1ps

`include "xc_macros.svh"

module xc_readout
	import xc_pkg::*;
(
	input  logic                                        intclk,
	input  logic                                        rst,
	input  logic                                        readout_start,
	input  logic [`XC_NUM_WORDS*`XC_RESOLUTION-1:0]     counts,
	output out_word_t                                   out,
	output logic                                        out_valid,
	output logic                                        last
);

	localparam int RES = `XC_RESOLUTION;

	logic [7:0] idx;
	logic       running;
	logic       active;
	logic       at_end;

	// Start pulse sends word 0 at once, idx rests at zero when idle
	assign active = readout_start | running;
	assign at_end = (idx == 8'(`XC_NUM_WORDS - 1));

	always_ff @(posedge intclk) begin
		if (rst) begin
			idx       <= '0;
			running   <= 1'b0;
			out_valid <= 1'b0;
			last      <= 1'b0;
		end else if (active) begin
			out_valid <= 1'b1;
			last      <= at_end;
			running   <= !at_end;
			idx       <= at_end ? '0 : idx + 1'b1;
		end else begin
			out_valid <= 1'b0;
			last      <= 1'b0;
		end
	end

	// Payload register
	always_ff @(posedge intclk) begin
		if (active) begin
			out.index <= idx;
			out.count <= counts[idx*RES+:RES];
		end
	end

endmodule

// ==== source/xc_sequencer.sv ====
// ========================================
// Integration sequencer
// Decodes commands, keeps the length and
// mode, steers clear, accept and readout
// ========================================

`timescale 1ns/1ps

`include "xc_macros.svh"

module xc_sequencer
	import xc_pkg::*;
(
	input  logic       intclk,
	input  logic       rst,
	input  cmd_u       cmd,
	input  logic       cmd_valid,
	input  logic       period_done,
	input  logic       last,
	output corr_ctl_t  corr_ctl,
	output logic       readout_start,
	output logic [5:0] len_log2,
	output logic       busy,
	input  logic       sample_valid
);

	seq_state_e state;
	logic       continuous;
	logic       is_abort;
	logic [5:0] len_req;

	assign is_abort = cmd_valid && (cmd.len.op == OP_ABORT);

	// Requests beyond the limit are clamped
	assign len_req = (cmd.len.len_log2 > 6'(`XC_LEN_MAX)) ? 6'(`XC_LEN_MAX) :
		cmd.len.len_log2;

	always_ff @(posedge intclk) begin
		if (rst) begin
			state         <= IDLE;
			continuous    <= 1'b0;
			len_log2      <= 6'(`XC_LEN_DEFAULT);
			readout_start <= 1'b0;
		end else begin
			readout_start <= 1'b0;
			if (is_abort) begin
				state <= IDLE;
			end else begin
				case (state)
					IDLE: begin
						if (cmd_valid && cmd.len.op == OP_SET_LEN) begin
							len_log2 <= len_req;
						end else if (cmd_valid && cmd.run.op == OP_START) begin
							continuous <= cmd.run.continuous;
							state      <= CLEAR;
						end
					end
					CLEAR: state <= INTEGRATE;
					INTEGRATE: begin
						// Last accept of the period, counters settle this edge
						if (period_done) begin
							state         <= READOUT;
							readout_start <= 1'b1;
						end
					end
					READOUT: begin
						if (last)
							state <= continuous ? CLEAR : IDLE;
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	assign corr_ctl.clear  = (state == CLEAR);
	assign corr_ctl.accept = (state == INTEGRATE) && sample_valid;
	assign busy            = (state != IDLE);

endmodule

// ==== source/xc_top.sv ====
// ========================================
// One-bit cross-correlator top level
// Sequencer, timer, history, counters
// and readout wired together
// ========================================

`timescale 1ns/1ps

`include "xc_macros.svh"

module xc_top
	import xc_pkg::*;
(
	input  logic                     intclk,
	input  logic                     rst,
	input  logic [`XC_NUM_LINES-1:0] line_in,
	input  logic                     sample_valid,
	input  cmd_u                     cmd,
	input  logic                     cmd_valid,
	output logic                     busy,
	output out_word_t                out,
	output logic                     out_valid,
	output logic                     frame_done
);

	corr_ctl_t                                  corr_ctl;
	logic                                       period_done;
	logic                                       readout_start;
	logic [5:0]                                 len_log2;
	logic [`XC_NUM_LINES*(`XC_LAGS-1)-1:0]      history;
	logic [`XC_NUM_WORDS*`XC_RESOLUTION-1:0]    counts;

	xc_sequencer u_seq (
		.intclk        (intclk),
		.rst           (rst),
		.cmd           (cmd),
		.cmd_valid     (cmd_valid),
		.period_done   (period_done),
		.last          (frame_done),
		.corr_ctl      (corr_ctl),
		.readout_start (readout_start),
		.len_log2      (len_log2),
		.busy          (busy),
		.sample_valid  (sample_valid)
	);

	xc_integ_timer u_timer (
		.intclk      (intclk),
		.rst         (rst),
		.corr_ctl    (corr_ctl),
		.len_log2    (len_log2),
		.period_done (period_done)
	);

	xc_delay_line u_delay (
		.intclk   (intclk),
		.rst      (rst),
		.corr_ctl (corr_ctl),
		.line_in  (line_in),
		.history  (history)
	);

	xc_corr_bank u_bank (
		.intclk   (intclk),
		.rst      (rst),
		.corr_ctl (corr_ctl),
		.line_in  (line_in),
		.history  (history),
		.counts   (counts)
	);

	// Final word flag doubles as the frame marker
	xc_readout u_readout (
		.intclk        (intclk),
		.rst           (rst),
		.readout_start (readout_start),
		.counts        (counts),
		.out           (out),
		.out_valid     (out_valid),
		.last          (frame_done)
	);

endmodule
